//--- hdl/aguBranch.sv
/*
 address generation and PC-relative branch target
 memory address is Rs + (Rt << scale), truncated to 48 bits
 branch target is PC + 2*Rt in 16-bit carry-select slices
 bits [47:32] only follow the sum when the jump-quadrant flag is set,
 and that flag lags SR bit 31 by one cycle
*/
`timescale 1ns/1ps
`include "ex1Stage_cfg.svh"

module aguBranch (
	input logic clock,
	input logic arstN,
	input ex1Pkg::ex1OperandT opnd,
	input logic [7:0] opUIxt,
	input logic srJq,
	output logic [`EX1_VALEN-1:0] memAddr,
	output logic [`EX1_XLEN-1:0] braTarget
);
	logic jqFlag;
	logic [`EX1_VALEN-1:0] idxScaled;
	logic [`EX1_VALEN-1:0] braDisp;
	logic [16:0] sumA0;
	logic [16:0] sumB0;
	logic [16:0] sumB1;
	logic [16:0] sumC0;
	logic [16:0] sumC1;
	logic carryA;
	logic carryB;
	logic [15:0] sliceB;
	logic [15:0] sliceC;

	// index scaled by 1, 2, 4 or 8
	assign idxScaled = opnd.valRt[`EX1_VALEN-1:0] << opUIxt[1:0];
	assign memAddr = opnd.valRs[`EX1_VALEN-1:0] + idxScaled;

	// displacement counts 16-bit words
	assign braDisp = {opnd.valRt[`EX1_VALEN-2:0], 1'b0};

	// low slice
	assign sumA0 = {1'b0, opnd.valPc[15:0]} + {1'b0, braDisp[15:0]};

	// middle slice, both carry-in cases
	assign sumB0 = {1'b0, opnd.valPc[31:16]} + {1'b0, braDisp[31:16]};
	assign sumB1 = {1'b0, opnd.valPc[31:16]} + {1'b0, braDisp[31:16]} + 17'd1;

	// upper slice, both carry-in cases
	assign sumC0 = {1'b0, opnd.valPc[47:32]} + {1'b0, braDisp[47:32]};
	assign sumC1 = {1'b0, opnd.valPc[47:32]} + {1'b0, braDisp[47:32]} + 17'd1;

	assign carryA = sumA0[16];
	assign sliceB = carryA ? sumB1[15:0] : sumB0[15:0];
	assign carryB = carryA ? sumB1[16] : sumB0[16];
	assign sliceC = carryB ? sumC1[15:0] : sumC0[15:0];

	// upper 16 bits never change on a relative branch
	always_comb begin
		braTarget = {opnd.valPc[63:48], opnd.valPc[47:32], sliceB, sumA0[15:0]};
		if (jqFlag)
			braTarget[47:32] = sliceC;
	end

	// jump quadrant, SR[31] of the previous cycle
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			jqFlag <= 1'b0;
		else
			jqFlag <= srJq;
	end

endmodule

//--- hdl/ex1Dispatch.sv
/*
 main decode of the effective opcode
 only starts a load or store, completion belongs to the next stage
 stall is requested while memory reports HOLD, the op is then replayed
 a flush forces both write ids to the null register
 branches assume a 48-bit address space, PC bits [63:48] carry mode bits
*/
`timescale 1ns/1ps
`include "ex1Stage_cfg.svh"

module ex1Dispatch (
	input ex1Pkg::uCmdE effCmd,
	input logic [7:0] opUIxt,
	input ex1Pkg::ex1OperandT opnd,
	input logic [`EX1_XLEN-1:0] srIn,
	input logic [`EX1_XLEN-1:0] lrIn,
	input logic [`EX1_XLEN-1:0] sysSr,
	input logic sysStall,
	input logic [`EX1_VALEN-1:0] memAddr,
	input logic [`EX1_XLEN-1:0] braTarget,
	input logic opBraFlush,
	input logic [1:0] opPreBra,
	input logic [1:0] memDataOK,
	output ex1Pkg::regWriteT rn1,
	output ex1Pkg::regWriteT cn1,
	output logic [`EX1_REGID_W-1:0] heldIdRn1,
	output logic [1:0] exHold,
	output ex1Pkg::memReqT mem,
	output logic [`EX1_XLEN-1:0] regOutLr,
	output logic [`EX1_XLEN-1:0] regOutSr
);
	import ex1Pkg::*;

	branchReqT bra;
	memOpmE memOpm;
	logic [`EX1_XLEN-1:0] dflVal;
	logic doDfl;
	logic doMem;
	logic held;
	logic stall;
	logic predTaken;

	// 01 means the fetch already followed the branch
	assign predTaken = (opPreBra == 2'b01);

	always_comb begin
		dflVal = '0;
		doDfl = 1'b0;
		doMem = 1'b0;
		memOpm = MO_READY;
		held = 1'b0;
		stall = 1'b0;
		regOutLr = lrIn;
		bra.take = 1'b0;
		bra.target = braTarget;

		case (effCmd)
			UC_NOP: begin
			end
			UC_LEA_MR: begin
				dflVal = {{(`EX1_XLEN-`EX1_VALEN){1'b0}}, memAddr};
				doDfl = 1'b1;
			end
			// store, sign and size from the sub-op field
			UC_MOV_RM: begin
				memOpm = memOpmE'({2'b10, opUIxt[2], opUIxt[5:4]});
				doMem = 1'b1;
			end
			// load, Rm busy until the data returns
			UC_MOV_MR: begin
				memOpm = memOpmE'({2'b01, opUIxt[2], opUIxt[5:4]});
				doMem = 1'b1;
				held = 1'b1;
			end
			UC_MOV_IR: begin
				doDfl = 1'b1;
				case (opUIxt[3:0])
					// shift-in forms, immediate arrives in Rt
					4'b0001: dflVal = {opnd.valRs[55:0], opnd.valRt[7:0]};
					4'b0010: dflVal = {opnd.valRs[47:0], opnd.valRt[15:0]};
					4'b0011: dflVal = {opnd.valRs[31:0], opnd.valRt[31:0]};
					default: dflVal = opnd.valRt;
				endcase
			end
			UC_OP_IXS: begin
				case (ixsOpE'(opUIxt[5:0]))
					IXS_NOP: begin
					end
					IXS_MOVT: begin
						dflVal = {{(`EX1_XLEN-1){1'b0}}, srIn[`EX1_SR_T]};
						doDfl = 1'b1;
					end
					IXS_MOVNT: begin
						dflVal = {{(`EX1_XLEN-1){1'b0}}, !srIn[`EX1_SR_T]};
						doDfl = 1'b1;
					end
					default: begin
						stall = 1'b1;
					end
				endcase
			end
			UC_OP_IXT: begin
				stall = sysStall;
			end
			// not taken, undo a prediction by going back to PC
			UC_BRA_NB: begin
				if (opPreBra != 2'b00) begin
					bra.take = 1'b1;
					bra.target = opnd.valPc;
				end
			end
			UC_BRA: begin
				bra.take = !predTaken;
			end
			UC_BSR: begin
				regOutLr = opnd.valPc;
				bra.take = !predTaken;
			end
			UC_JMP: begin
				bra.target = {opnd.valPc[63:48], opnd.valRs[47:0]};
				// return through LR or DHR restores the saved mode bits
				if ((opnd.idRs == `EX1_GR_LR) || (opnd.idRs == `EX1_GR_DHR))
					bra.target[63:48] = opnd.valRs[63:48];
				bra.take = !predTaken;
			end
			UC_JSR: begin
				regOutLr = opnd.valPc;
				bra.target = {opnd.valPc[63:48], opnd.valRs[47:0]};
				bra.take = 1'b1;
			end
			// finished in a later stage
			UC_ALU3, UC_MUL3, UC_BLINT: begin
				held = 1'b1;
			end
			// INVOP lands here too
			default: begin
				stall = 1'b1;
			end
		endcase

		rn1.id = doDfl ? opnd.idRm : `EX1_GR_ZZR;
		rn1.val = dflVal;
		cn1.id = bra.take ? `EX1_CR_PC : `EX1_GR_ZZR;
		cn1.val = bra.target;

		if (doMem && (memDataOK == `EX1_MEMOK_HOLD))
			stall = 1'b1;

		if (opBraFlush) begin
			rn1.id = `EX1_GR_ZZR;
			cn1.id = `EX1_GR_ZZR;
		end
	end

	assign heldIdRn1 = held ? opnd.idRm : `EX1_GR_ZZR;
	assign exHold = {held, stall};

	// store data always from Rm
	assign mem.addr = memAddr;
	assign mem.opm = memOpm;
	assign mem.data = opnd.valRm;

	// SR from the system unit, unchanged for other ops
	assign regOutSr = sysSr;

endmodule

//--- hdl/ex1Pkg.sv
/*
 types for the first execute stage
 opcode and sub-op encodings must match the decoder upstream
 memory op codes are {class, sign, size}, class 01 load and 10 store
*/
`include "ex1Stage_cfg.svh"

package ex1Pkg;

	// micro-opcodes, ALU3/MUL3/BLINT finish in a later stage
	typedef enum logic [5:0] {
		UC_NOP = 6'h00,
		UC_MOV_RM = 6'h01,
		UC_MOV_MR = 6'h02,
		UC_LEA_MR = 6'h03,
		UC_MOV_IR = 6'h04,
		UC_BRA = 6'h08,
		UC_BSR = 6'h09,
		UC_JMP = 6'h0A,
		UC_JSR = 6'h0B,
		UC_BRA_NB = 6'h0C,
		UC_ALU3 = 6'h10,
		UC_MUL3 = 6'h14,
		UC_BLINT = 6'h18,
		UC_OP_IXS = 6'h20,
		UC_OP_IXT = 6'h21,
		UC_INVOP = 6'h3F
	} uCmdE;

	// IXT system sub-ops
	typedef enum logic [5:0] {
		IXT_NOP = 6'h00,
		IXT_SLEEP = 6'h01,
		IXT_BREAK = 6'h02,
		IXT_CLRT = 6'h04,
		IXT_SETT = 6'h05,
		IXT_CLRS = 6'h06,
		IXT_SETS = 6'h07,
		IXT_NOTT = 6'h08,
		IXT_NOTS = 6'h09,
		IXT_RTE = 6'h0C,
		IXT_TRAPA = 6'h0D
	} ixtOpE;

	// IXS sub-ops handled here
	typedef enum logic [5:0] {
		IXS_NOP = 6'h00,
		IXS_MOVT = 6'h01,
		IXS_MOVNT = 6'h02
	} ixsOpE;

	typedef enum logic [1:0] {
		CC_AL = 2'b00,
		CC_NV = 2'b01,
		CC_CT = 2'b10,
		CC_CF = 2'b11
	} condE;

	// size 00 byte, 01 word, 10 long, 11 quad
	typedef enum logic [4:0] {
		MO_READY = 5'b00000,
		MO_LD_UB = 5'b01000,
		MO_LD_UW = 5'b01001,
		MO_LD_UL = 5'b01010,
		MO_LD_UQ = 5'b01011,
		MO_LD_SB = 5'b01100,
		MO_LD_SW = 5'b01101,
		MO_LD_SL = 5'b01110,
		MO_LD_SQ = 5'b01111,
		MO_ST_UB = 5'b10000,
		MO_ST_UW = 5'b10001,
		MO_ST_UL = 5'b10010,
		MO_ST_UQ = 5'b10011,
		MO_ST_SB = 5'b10100,
		MO_ST_SW = 5'b10101,
		MO_ST_SL = 5'b10110,
		MO_ST_SQ = 5'b10111
	} memOpmE;

	// register operands from the register file, plus the synthesized PC
	typedef struct packed {
		logic [`EX1_REGID_W-1:0] idRs;
		logic [`EX1_REGID_W-1:0] idRt;
		logic [`EX1_REGID_W-1:0] idRm;
		logic [`EX1_XLEN-1:0] valRs;
		logic [`EX1_XLEN-1:0] valRt;
		logic [`EX1_XLEN-1:0] valRm;
		logic [`EX1_XLEN-1:0] valPc;
	} ex1OperandT;

	typedef struct packed {
		logic [`EX1_REGID_W-1:0] id;
		logic [`EX1_XLEN-1:0] val;
	} regWriteT;

	typedef struct packed {
		logic [`EX1_VALEN-1:0] addr;
		memOpmE opm;
		logic [`EX1_XLEN-1:0] data;
	} memReqT;

	typedef struct packed {
		logic take;
		logic [`EX1_XLEN-1:0] target;
	} branchReqT;

endpackage

//--- hdl/ex1Stage.sv
/*
 first execute stage of the 64-bit core
 combinational from inputs to outputs, no handshake
 the only state is the jump-quadrant flag inside the AGU
 memory ops are only issued here, exHold[0] asks for a replay
*/
`timescale 1ns/1ps
`include "ex1Stage_cfg.svh"

module ex1Stage (
	input logic clock,
	input logic arstN,
	input logic [7:0] opUCmd,
	input logic [7:0] opUIxt,
	input ex1Pkg::ex1OperandT opnd,
	input logic opBraFlush,
	input logic [1:0] opPreBra,
	input logic [`EX1_XLEN-1:0] regInSr,
	input logic [`EX1_XLEN-1:0] regInLr,
	input logic [1:0] memDataOK,
	input logic regInExc15,
	output ex1Pkg::regWriteT rn1,
	output ex1Pkg::regWriteT cn1,
	output logic [`EX1_REGID_W-1:0] heldIdRn1,
	output logic [1:0] exHold,
	output logic [15:0] exTrapExc,
	output ex1Pkg::memReqT mem,
	output logic [`EX1_XLEN-1:0] regOutLr,
	output logic [`EX1_XLEN-1:0] regOutSr,
	output logic [7:0] opUCmdOut
);
	import ex1Pkg::*;

	uCmdE effCmd;
	logic [`EX1_VALEN-1:0] memAddr;
	logic [`EX1_XLEN-1:0] braTarget;
	logic [`EX1_XLEN-1:0] sysSr;
	logic sysStall;

	predGate uPredGate (
		.opUCmd(opUCmd),
		.opBraFlush(opBraFlush),
		.srT(regInSr[`EX1_SR_T]),
		.effCmd(effCmd),
		.opUCmdOut(opUCmdOut)
	);

	aguBranch uAguBranch (
		.clock(clock),
		.arstN(arstN),
		.opnd(opnd),
		.opUIxt(opUIxt),
		.srJq(regInSr[`EX1_SR_JQ]),
		.memAddr(memAddr),
		.braTarget(braTarget)
	);

	// system unit only active for IXT ops that survived predication
	sysOpUnit uSysOpUnit (
		.valid(effCmd == UC_OP_IXT),
		.ixtOp(ixtOpE'(opUIxt[5:0])),
		.srIn(regInSr),
		.rmId(opnd.idRm),
		.excIn15(regInExc15),
		.srOut(sysSr),
		.trapExc(exTrapExc),
		.stall(sysStall)
	);

	ex1Dispatch uDispatch (
		.effCmd(effCmd),
		.opUIxt(opUIxt),
		.opnd(opnd),
		.srIn(regInSr),
		.lrIn(regInLr),
		.sysSr(sysSr),
		.sysStall(sysStall),
		.memAddr(memAddr),
		.braTarget(braTarget),
		.opBraFlush(opBraFlush),
		.opPreBra(opPreBra),
		.memDataOK(memDataOK),
		.rn1(rn1),
		.cn1(cn1),
		.heldIdRn1(heldIdRn1),
		.exHold(exHold),
		.mem(mem),
		.regOutLr(regOutLr),
		.regOutSr(regOutSr)
	);

endmodule

//--- hdl/ex1Stage_cfg.svh
/*
 widths, register ids and status codes shared by the execute stage
 register ids are 6 bits, GPR and control register space share one id range
 memory status is the 2-bit level from the data cache, HOLD means busy
 SR.T is bit 0 and SR.S is bit 1
*/
`ifndef EX1_STAGE_CFG_SVH
`define EX1_STAGE_CFG_SVH

// data, virtual address and register id widths
`define EX1_XLEN 64
`define EX1_VALEN 48
`define EX1_REGID_W 6

// register ids
`define EX1_GR_ZZR 6'h3F
`define EX1_GR_DHR 6'h01
`define EX1_GR_LR 6'h31
`define EX1_CR_PC 6'h30

// memory status, busy level
`define EX1_MEMOK_HOLD 2'b10

// SR bit offsets
`define EX1_SR_T 0
`define EX1_SR_S 1
`define EX1_SR_JQ 31

`endif

//--- hdl/predGate.sv
/*
 predicated issue, single-bit predicate mode only (SR.T)
 a flush disables every op regardless of condition
 a suppressed BRA still goes down as BRA_NB so a wrong prediction gets fixed
*/
`timescale 1ns/1ps

module predGate (
	input logic [7:0] opUCmd,
	input logic opBraFlush,
	input logic srT,
	output ex1Pkg::uCmdE effCmd,
	output logic [7:0] opUCmdOut
);
	import ex1Pkg::*;

	condE cond;
	uCmdE rawCmd;
	logic opEnable;

	// condition in the top two bits, opcode below
	assign cond = condE'(opUCmd[7:6]);
	assign rawCmd = uCmdE'(opUCmd[5:0]);

	always_comb begin
		case (cond)
			CC_AL: opEnable = 1'b1;
			CC_NV: opEnable = 1'b0;
			CC_CT: opEnable = srT;
			default: opEnable = !srT;
		endcase
		if (opBraFlush)
			opEnable = 1'b0;
	end

	always_comb begin
		if (opEnable)
			effCmd = rawCmd;
		else if ((rawCmd == UC_BRA) && !opBraFlush)
			effCmd = UC_BRA_NB;
		else
			effCmd = UC_NOP;
	end

	// predicate already resolved, later stages see AL
	assign opUCmdOut = {CC_AL, effCmd};

endmodule

//--- hdl/sysOpUnit.sv
/*
 IXT system sub-ops: SR flag updates, traps and BREAK
 BREAK stalls the pipe unless the debug exception bit 15 is set
 any sub-op not listed stalls until the op is replaced upstream
 with valid low, SR passes through and nothing else is raised
*/
`timescale 1ns/1ps
`include "ex1Stage_cfg.svh"

module sysOpUnit (
	input logic valid,
	input ex1Pkg::ixtOpE ixtOp,
	input logic [`EX1_XLEN-1:0] srIn,
	input logic [`EX1_REGID_W-1:0] rmId,
	input logic excIn15,
	output logic [`EX1_XLEN-1:0] srOut,
	output logic [15:0] trapExc,
	output logic stall
);
	import ex1Pkg::*;

	always_comb begin
		srOut = srIn;
		trapExc = 16'h0000;
		stall = 1'b0;
		if (valid) begin
			case (ixtOp)
				IXT_NOP, IXT_SLEEP: begin
				end
				IXT_BREAK: begin
					stall = !excIn15;
				end
				// T flag
				IXT_CLRT: begin
					srOut[`EX1_SR_T] = 1'b0;
				end
				IXT_SETT: begin
					srOut[`EX1_SR_T] = 1'b1;
				end
				IXT_NOTT: begin
					srOut[`EX1_SR_T] = !srIn[`EX1_SR_T];
				end
				// S flag
				IXT_CLRS: begin
					srOut[`EX1_SR_S] = 1'b0;
				end
				IXT_SETS: begin
					srOut[`EX1_SR_S] = 1'b1;
				end
				IXT_NOTS: begin
					srOut[`EX1_SR_S] = !srIn[`EX1_SR_S];
				end
				// return from exception
				IXT_RTE: begin
					trapExc = 16'hFF00;
				end
				// trap number from the low bits of the Rm field
				IXT_TRAPA: begin
					trapExc = {12'hC08, rmId[3:0]};
				end
				default: begin
					stall = 1'b1;
				end
			endcase
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module ex1Stage_tb -o simv \
	&& ./obj_dir/simv | grep "Simulation finished: PASS" \
	&& exit 0 \
	|| exit 1

//--- sources.f
+incdir+hdl
hdl/ex1Pkg.sv
hdl/predGate.sv
hdl/aguBranch.sv
hdl/sysOpUnit.sv
hdl/ex1Dispatch.sv
hdl/ex1Stage.sv
tests/ex1Stage_tb.sv

//--- tests/ex1Stage_tb.sv
/*
 testbench for the first execute stage
 replays tests/ex1_stim.txt, one vector per clock, inputs then expected outputs
 Rt id, Rm value and LR input are fixed here and not part of the vectors
 outputs are checked at the falling edge, the first mismatch ends the run
*/
`timescale 1ns/1ps

module ex1Stage_tb;
	import ex1Pkg::*;

	// one replayed vector, inputs then expected outputs
	typedef struct packed {
		logic [7:0] uCmd;
		logic [7:0] uIxt;
		logic flush;
		logic [1:0] preBra;
		logic [63:0] sr;
		logic [1:0] memOk;
		logic exc15;
		logic [5:0] idRs;
		logic [5:0] idRm;
		logic [63:0] valRs;
		logic [63:0] valRt;
		logic [63:0] valPc;
		logic [5:0] expRn1Id;
		logic [63:0] expRn1Val;
		logic [5:0] expCn1Id;
		logic [63:0] expCn1Val;
		logic [5:0] expHeld;
		logic [1:0] expHold;
		logic [15:0] expTrap;
		logic [47:0] expAddr;
		logic [4:0] expOpm;
		logic [63:0] expLr;
		logic [63:0] expSr;
		logic [7:0] expUCmdOut;
	} vectorT;

	// Rm value driven with every vector
	localparam logic [63:0] rmValue = 64'h77;

	logic clock;
	logic arstN;
	logic [7:0] opUCmd;
	logic [7:0] opUIxt;
	ex1OperandT opnd;
	logic opBraFlush;
	logic [1:0] opPreBra;
	logic [63:0] regInSr;
	logic [63:0] regInLr;
	logic [1:0] memDataOK;
	logic regInExc15;
	regWriteT rn1;
	regWriteT cn1;
	logic [5:0] heldIdRn1;
	logic [1:0] exHold;
	logic [15:0] exTrapExc;
	memReqT mem;
	logic [63:0] regOutLr;
	logic [63:0] regOutSr;
	logic [7:0] opUCmdOut;

	vectorT vecs[$];
	logic loaded;

	ex1Stage UUT (
		.clock(clock),
		.arstN(arstN),
		.opUCmd(opUCmd),
		.opUIxt(opUIxt),
		.opnd(opnd),
		.opBraFlush(opBraFlush),
		.opPreBra(opPreBra),
		.regInSr(regInSr),
		.regInLr(regInLr),
		.memDataOK(memDataOK),
		.regInExc15(regInExc15),
		.rn1(rn1),
		.cn1(cn1),
		.heldIdRn1(heldIdRn1),
		.exHold(exHold),
		.exTrapExc(exTrapExc),
		.mem(mem),
		.regOutLr(regOutLr),
		.regOutSr(regOutSr),
		.opUCmdOut(opUCmdOut)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = !clock;
	end

	// compare one output, stop at the first difference
	task automatic checkValue(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		assert (actVal === expVal)
		else begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expVal, actVal);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic loadVectors();
		int fd;
		int cnt;
		string line;
		logic [63:0] f [0:23];
		vectorT v;
		fd = $fopen("tests/ex1_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file tests/ex1_stim.txt");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			// skip blank and comment lines
			if ((line.len() > 1) && (line[0] != "#")) begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
					f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
					f[22], f[23]);
				if (cnt == 24) begin
					v.uCmd = f[0][7:0];
					v.uIxt = f[1][7:0];
					v.flush = f[2][0];
					v.preBra = f[3][1:0];
					v.sr = f[4];
					v.memOk = f[5][1:0];
					v.exc15 = f[6][0];
					v.idRs = f[7][5:0];
					v.idRm = f[8][5:0];
					v.valRs = f[9];
					v.valRt = f[10];
					v.valPc = f[11];
					v.expRn1Id = f[12][5:0];
					v.expRn1Val = f[13];
					v.expCn1Id = f[14][5:0];
					v.expCn1Val = f[15];
					v.expHeld = f[16][5:0];
					v.expHold = f[17][1:0];
					v.expTrap = f[18][15:0];
					v.expAddr = f[19][47:0];
					v.expOpm = f[20][4:0];
					v.expLr = f[21];
					v.expSr = f[22];
					v.expUCmdOut = f[23][7:0];
					vecs.push_back(v);
				end
			end
		end
		$fclose(fd);
	endtask

	// watchdog sized from the vector count
	initial begin
		wait (loaded === 1'b1);
		#(40 * (vecs.size() + 20));
		$display("watchdog timeout, the vector replay did not finish in time");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

	initial begin
		loaded = 1'b0;
		arstN = 1'b0;
		opUCmd = 8'h00;
		opUIxt = 8'h00;
		opnd = '0;
		opBraFlush = 1'b0;
		opPreBra = 2'b00;
		regInSr = 64'h0;
		regInLr = 64'hAAAA;
		memDataOK = 2'b00;
		regInExc15 = 1'b0;

		loadVectors();
		loaded = 1'b1;
		if (vecs.size() == 0) begin
			$display("the stimulus file holds no vectors");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

		// reset for two cycles
		repeat (2) @(posedge clock);
		arstN <= 1'b1;

		foreach (vecs[i]) begin
			@(posedge clock);
			opUCmd <= vecs[i].uCmd;
			opUIxt <= vecs[i].uIxt;
			opBraFlush <= vecs[i].flush;
			opPreBra <= vecs[i].preBra;
			regInSr <= vecs[i].sr;
			memDataOK <= vecs[i].memOk;
			regInExc15 <= vecs[i].exc15;
			opnd <= '{idRs: vecs[i].idRs, idRt: 6'h03, idRm: vecs[i].idRm,
				valRs: vecs[i].valRs, valRt: vecs[i].valRt, valRm: rmValue,
				valPc: vecs[i].valPc};
			@(negedge clock);
			checkValue("rn1.id", vecs[i].expRn1Id, rn1.id);
			checkValue("rn1.val", vecs[i].expRn1Val, rn1.val);
			checkValue("cn1.id", vecs[i].expCn1Id, cn1.id);
			checkValue("cn1.val", vecs[i].expCn1Val, cn1.val);
			checkValue("heldIdRn1", vecs[i].expHeld, heldIdRn1);
			checkValue("exHold", vecs[i].expHold, exHold);
			checkValue("exTrapExc", vecs[i].expTrap, exTrapExc);
			checkValue("mem.addr", vecs[i].expAddr, mem.addr);
			checkValue("mem.opm", vecs[i].expOpm, mem.opm);
			// store data always comes from Rm
			checkValue("mem.data", rmValue, mem.data);
			checkValue("regOutLr", vecs[i].expLr, regOutLr);
			checkValue("regOutSr", vecs[i].expSr, regOutSr);
			checkValue("opUCmdOut", vecs[i].expUCmdOut, opUCmdOut);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- tests/ex1_stim.txt
# in: ucmd uixt flush prebra sr memok exc15 idRs idRm valRs valRt valPc
# out: rn1Id rn1Val cn1Id cn1Val heldId exHold trap memAddr opm lrOut srOut ucmdOut
10 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 05 2 0 1010 00 AAAA 0 10
50 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 0 00
90 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 0 00
90 00 0 0 1 0 0 02 05 1000 10 40000 3F 0 3F 40020 05 2 0 1010 00 AAAA 1 10
D0 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 05 2 0 1010 00 AAAA 0 10
D0 00 0 0 1 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 1 00
10 00 1 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 0 00
88 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 0 0C
88 00 0 1 0 0 0 02 05 1000 10 40000 3F 0 30 40000 3F 0 0 1010 00 AAAA 0 0C
03 00 0 0 0 0 0 02 05 1000 10 40000 05 1010 3F 40020 3F 0 0 1010 00 AAAA 0 03
20 01 0 0 1 0 0 02 05 1000 10 40000 05 1 3F 40020 3F 0 0 1020 00 AAAA 1 20
20 02 0 0 1 0 0 02 05 1000 10 40000 05 0 3F 40020 3F 0 0 1040 00 AAAA 1 20
04 01 0 0 0 0 0 02 05 1000 10 40000 05 100010 3F 40020 3F 0 0 1020 00 AAAA 0 04
04 02 0 0 0 0 0 02 05 1000 10 40000 05 10000010 3F 40020 3F 0 0 1040 00 AAAA 0 04
04 03 0 0 0 0 0 02 05 1000 10 40000 05 100000000010 3F 40020 3F 0 0 1080 00 AAAA 0 04
04 03 1 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1080 00 AAAA 0 00
02 36 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 05 2 0 1040 0F AAAA 0 02
02 36 0 0 0 2 0 02 05 1000 10 40000 3F 0 3F 40020 05 3 0 1040 0F AAAA 0 02
01 10 0 0 0 2 0 02 05 1000 10 40000 3F 0 3F 40020 3F 1 0 1010 11 AAAA 0 01
08 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 30 40020 3F 0 0 1010 00 AAAA 0 08
08 00 0 1 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 0 08
08 00 0 2 0 0 0 02 05 1000 10 40000 3F 0 30 40020 3F 0 0 1010 00 AAAA 0 08
09 00 0 1 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 40000 0 09
09 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 30 40020 3F 0 0 1010 00 40000 0 09
0A 00 0 0 0 0 0 02 05 FFFF123456789ABC 10 40000 3F 0 30 123456789ABC 3F 0 0 123456789ACC 00 AAAA 0 0A
0A 00 0 0 0 0 0 31 05 FFFF123456789ABC 10 40000 3F 0 30 FFFF123456789ABC 3F 0 0 123456789ACC 00 AAAA 0 0A
0A 00 0 1 0 0 0 02 05 FFFF123456789ABC 10 40000 3F 0 3F 123456789ABC 3F 0 0 123456789ACC 00 AAAA 0 0A
0B 00 0 1 0 0 0 02 05 FFFF123456789ABC 10 40000 3F 0 30 123456789ABC 3F 0 0 123456789ACC 00 40000 0 0B
08 00 0 0 80000000 0 0 02 05 1000 8000 1FFFF0000 3F 0 30 100000000 3F 0 0 9000 00 AAAA 80000000 08
08 00 0 0 80000000 0 0 02 05 1000 8000 1FFFF0000 3F 0 30 200000000 3F 0 0 9000 00 AAAA 80000000 08
21 04 0 0 3 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 2 21
21 05 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1020 00 AAAA 1 21
21 06 0 0 3 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1040 00 AAAA 1 21
21 07 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1080 00 AAAA 2 21
21 08 0 0 1 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1010 00 AAAA 0 21
21 09 0 0 1 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1020 00 AAAA 3 21
21 0C 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 FF00 1010 00 AAAA 0 21
21 0D 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 0 C085 1020 00 AAAA 0 21
21 02 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 1 0 1040 00 AAAA 0 21
21 02 0 0 0 0 1 02 05 1000 10 40000 3F 0 3F 40020 3F 0 0 1040 00 AAAA 0 21
3E 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 1 0 1010 00 AAAA 0 3E
3F 00 0 0 0 0 0 02 05 1000 10 40000 3F 0 3F 40020 3F 1 0 1010 00 AAAA 0 3F
